// File: include/video_defs.svh
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// horizontal raster, in pixel clocks
`define H_ACTIVE 32
`define H_FP     2
`define H_SYNC   4
`define H_BP     2
`define H_TOTAL  (`H_ACTIVE + `H_FP + `H_SYNC + `H_BP) // 40

// vertical raster, in lines
`define V_ACTIVE 24
`define V_FP     1
`define V_SYNC   2
`define V_BP     1
`define V_TOTAL  (`V_ACTIVE + `V_FP + `V_SYNC + `V_BP) // 28

`define SCALE_SHIFT 2 // one buffer cell = 4x4 screen pixels

// frame buffer geometry
`define FB_W     8
`define FB_H     6
`define FB_DEPTH (`FB_W * `FB_H) // 48 words
`define FB_AW    6

`define APB_AW 4 // byte address bits

`endif

// File: logic/fb_regs.sv
`timescale 1ns/1ps
`include "video_defs.svh"

// apb slave, control regs and frame buffer write pointer
module fb_regs
  import video_pkg::*, regs_pkg::*;
(
  input  logic              clk_pixel,
  input  logic              arst_n,
  // apb
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [`APB_AW-1:0] paddr,
  input  logic [31:0]       pwdata,
  output logic [31:0]       prdata,
  output logic              pready,
  output logic              pslverr,
  raster_if.sink            rast,    // new_frame only
  // frame buffer write port
  output logic              wr_en,
  output logic [`FB_AW-1:0] wr_addr,
  output px_word_u          wr_data,
  output logic              enable,
  output px_mode_e          mode
);
  reg_addr_e         addr;
  logic              access;   // apb access phase
  logic              mapped;
  logic              wr_ok;    // write that takes effect
  logic [`FB_AW-1:0] pix_addr;
  logic [7:0]        frame_cnt;

  assign addr   = reg_addr_e'(paddr);
  assign access = psel && penable;
  assign mapped = addr inside {REG_CTRL, REG_PIX_ADDR, REG_PIX_DATA, REG_STATUS};
  assign wr_ok  = access && pwrite && mapped && (addr != REG_STATUS);

  assign pready  = access; // never any wait states
  assign pslverr = access && (!mapped || (pwrite && addr == REG_STATUS));

  // pixel write goes out in the access cycle itself
  assign wr_en   = wr_ok && (addr == REG_PIX_DATA);
  assign wr_addr = pix_addr;
  assign wr_data = px_word_u'(pwdata[15:0]);

  // read mux, zero outside a read access
  always_comb begin
    prdata = '0;
    if (access && !pwrite) begin
      case (addr)
        REG_CTRL:     prdata = {30'b0, mode, enable};
        REG_PIX_ADDR: prdata = {{(32 - `FB_AW){1'b0}}, pix_addr};
        REG_STATUS:   prdata = {24'b0, frame_cnt};
        default:      prdata = '0; // pix_data reads back 0
      endcase
    end
  end

  always_ff @(posedge clk_pixel or negedge arst_n) begin
    if (!arst_n) begin
      enable    <= 1'b0;
      mode      <= PX_RGB565;
      pix_addr  <= '0;
      frame_cnt <= '0;
    end else begin
      if (rast.new_frame) begin
        frame_cnt <= frame_cnt + 8'd1; // wraps at 255
      end
      if (wr_ok) begin
        case (addr)
          REG_CTRL: begin
            enable <= pwdata[CTRL_EN_BIT];
            mode   <= px_mode_e'(pwdata[CTRL_MODE_BIT]);
          end
          REG_PIX_ADDR: pix_addr <= pwdata[`FB_AW-1:0];
          REG_PIX_DATA: begin
            // auto increment with wrap at the last word
            pix_addr <= (pix_addr == `FB_AW'(`FB_DEPTH - 1)) ? '0 : pix_addr + 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// File: logic/frame_buffer.sv
`timescale 1ns/1ps
`include "video_defs.svh"

// simple dual port ram, one write and one registered read port
module frame_buffer
  import video_pkg::*;
(
  input  logic              clk_pixel,
  input  logic              wr_en,
  input  logic [`FB_AW-1:0] wr_addr,
  input  px_word_u          wr_data,
  input  logic [`FB_AW-1:0] rd_addr,
  output px_word_u          rd_data // one clock after rd_addr
);
  px_word_u mem [`FB_DEPTH];

  always_ff @(posedge clk_pixel) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data <= mem[rd_addr]; // same-address collision undefined
  end

endmodule

// File: logic/pixel_unpack.sv
`timescale 1ns/1ps
`include "video_defs.svh"

// frame buffer fetch and word decode, two clocks behind the raster
module pixel_unpack
  import video_pkg::*, regs_pkg::*;
(
  input  logic              clk_pixel,
  input  logic              arst_n,
  raster_if.sink            rast,
  input  logic              enable,
  input  px_mode_e          mode,
  output logic [`FB_AW-1:0] rd_addr,
  input  px_word_u          rd_data,
  output rgb888_t           pix,
  output logic [1:0]        ctrl,  // {vsync, hsync}
  output logic              vde
);
  logic [`FB_AW-1:0] row_idx, col_idx;
  logic              sel_d1;  // right gray byte
  logic [1:0]        ctrl_d1;
  logic              vde_d1;
  logic [7:0]        gray;
  rgb888_t           pix_nxt;

  // scaled cell coordinates
  assign row_idx = `FB_AW'(rast.vpos >> `SCALE_SHIFT);
  assign col_idx = `FB_AW'(rast.hpos >> `SCALE_SHIFT);
  assign rd_addr = rast.active ? `FB_AW'(row_idx * `FB_W + col_idx) : '0; // park in blanking

  // stage 1, waits for the ram
  always_ff @(posedge clk_pixel or negedge arst_n) begin
    if (!arst_n) begin
      sel_d1  <= 1'b0;
      ctrl_d1 <= 2'b00;
      vde_d1  <= 1'b0;
    end else begin
      sel_d1  <= rast.hpos[`SCALE_SHIFT-1]; // half cell picks the byte
      ctrl_d1 <= {rast.vsync, rast.hsync};
      vde_d1  <= rast.active;
    end
  end

  always_comb begin
    gray = sel_d1 ? rd_data.mono.gray_right : rd_data.mono.gray_left;
    if (!enable) begin
      pix_nxt = '0; // blank screen
    end else if (mode == PX_MONO) begin
      pix_nxt = '{r: gray, g: gray, b: gray};
    end else begin
      pix_nxt.r = {rd_data.rgb.r, 3'b000}; // zero fill low bits
      pix_nxt.g = {rd_data.rgb.g, 2'b00};
      pix_nxt.b = {rd_data.rgb.b, 3'b000};
    end
  end

  // stage 2, pixel register
  always_ff @(posedge clk_pixel) begin
    pix <= pix_nxt;
  end

  always_ff @(posedge clk_pixel or negedge arst_n) begin
    if (!arst_n) begin
      ctrl <= 2'b00;
      vde  <= 1'b0;
    end else begin
      ctrl <= ctrl_d1;
      vde  <= vde_d1;
    end
  end

endmodule

// File: logic/raster_if.sv
`timescale 1ns/1ps

// raster position and sync bundle from the timing generator
interface raster_if
  import video_pkg::*;
();
  hpos_t hpos;      // current column
  vpos_t vpos;      // current line
  logic  active;    // inside visible area
  logic  hsync;     // active high
  logic  vsync;     // active high
  logic  new_frame; // one clock at 0,0

  modport source (
    output hpos, vpos, active, hsync, vsync, new_frame
  );

  modport sink (
    input hpos, vpos, active, hsync, vsync, new_frame
  );

endinterface

// File: logic/regs_pkg.sv
`include "video_defs.svh"

package regs_pkg;

  typedef enum logic {
    PX_RGB565 = 1'b0,
    PX_MONO   = 1'b1
  } px_mode_e;

  // apb register map, byte addresses
  typedef enum logic [`APB_AW-1:0] {
    REG_CTRL     = 'h0, // enable, mode
    REG_PIX_ADDR = 'h4, // write pointer
    REG_PIX_DATA = 'h8, // write-only, pushes one word
    REG_STATUS   = 'hC  // frame count, read-only
  } reg_addr_e;

  localparam int CTRL_EN_BIT   = 0;
  localparam int CTRL_MODE_BIT = 1;

endpackage

// File: logic/tmds_encoder.sv
`timescale 1ns/1ps

// dvi 8b/10b channel encoder
module tmds_encoder (
  input  logic       clk_pixel,
  input  logic       arst_n,
  input  logic [7:0] data,
  input  logic [1:0] ctrl,  // {c1, c0}
  input  logic       vde,
  output logic [9:0] tmds
);
  localparam logic [9:0] CTL_00 = 10'b1101010100;
  localparam logic [9:0] CTL_01 = 10'b0010101011;
  localparam logic [9:0] CTL_10 = 10'b0101010100;
  localparam logic [9:0] CTL_11 = 10'b1010101011;

  logic [3:0]        n1_d, n1_q, n0_q;
  logic              use_xnor;
  logic [8:0]        q_m;       // transition minimized word
  logic signed [4:0] bal;       // ones minus zeros in q_m[7:0]
  logic signed [4:0] disparity; // running, ones minus zeros sent
  logic signed [4:0] disp_nxt;
  logic [9:0]        q_out;

  assign n1_d = 4'($countones(data));

  // xor or xnor chain, fewer transitions either way
  always_comb begin
    use_xnor = (n1_d > 4'd4) || (n1_d == 4'd4 && !data[0]);
    q_m[0]   = data[0];
    for (int i = 1; i < 8; i++) begin
      q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
    end
    q_m[8] = ~use_xnor;
  end

  assign n1_q = 4'($countones(q_m[7:0]));
  assign n0_q = 4'd8 - n1_q;
  assign bal  = $signed({1'b0, n1_q}) - $signed({1'b0, n0_q});

  // dc balance, invert when it pulls the disparity back toward 0
  always_comb begin
    if (disparity == 0 || bal == 0) begin
      q_out    = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
      disp_nxt = q_m[8] ? disparity + bal : disparity - bal;
    end else if ((disparity > 0 && bal > 0) || (disparity < 0 && bal < 0)) begin
      q_out    = {1'b1, q_m[8], ~q_m[7:0]};
      disp_nxt = disparity + (q_m[8] ? 5'sd2 : 5'sd0) - bal;
    end else begin
      q_out    = {1'b0, q_m[8], q_m[7:0]};
      disp_nxt = disparity - (q_m[8] ? 5'sd0 : 5'sd2) + bal;
    end
  end

  always_ff @(posedge clk_pixel or negedge arst_n) begin
    if (!arst_n) begin
      tmds      <= CTL_00;
      disparity <= '0;
    end else if (vde) begin
      tmds      <= q_out;
      disparity <= disp_nxt;
    end else begin
      disparity <= '0; // restart balance every blanking
      case (ctrl)
        2'b00:   tmds <= CTL_00;
        2'b01:   tmds <= CTL_01;
        2'b10:   tmds <= CTL_10;
        default: tmds <= CTL_11;
      endcase
    end
  end

endmodule

// File: logic/video_out_top.sv
`timescale 1ns/1ps
`include "video_defs.svh"

// frame buffer scanout to three tmds channels
module video_out_top
  import video_pkg::*, regs_pkg::*;
(
  input  logic               clk_pixel,
  input  logic               arst_n,
  // apb slave
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [`APB_AW-1:0] paddr,
  input  logic [31:0]        pwdata,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  // 10 bit symbols, one per channel
  output logic [9:0]         tmds_blue,
  output logic [9:0]         tmds_green,
  output logic [9:0]         tmds_red
);
  raster_if rast ();

  logic              fb_wr_en;
  logic [`FB_AW-1:0] fb_wr_addr, fb_rd_addr;
  px_word_u          fb_wr_data, fb_rd_data;
  logic              enable;
  px_mode_e          mode;
  rgb888_t           pix;       // 2 clocks behind raster
  logic [1:0]        ctrl;      // {vsync, hsync} aligned with pix
  logic              vde;

  video_timing u_timing (
    .clk_pixel (clk_pixel),
    .arst_n    (arst_n),
    .rast      (rast.source)
  );

  frame_buffer u_fb (
    .clk_pixel (clk_pixel),
    .wr_en     (fb_wr_en),
    .wr_addr   (fb_wr_addr),
    .wr_data   (fb_wr_data),
    .rd_addr   (fb_rd_addr),
    .rd_data   (fb_rd_data)
  );

  fb_regs u_regs (
    .clk_pixel (clk_pixel),
    .arst_n    (arst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .rast      (rast.sink),
    .wr_en     (fb_wr_en),
    .wr_addr   (fb_wr_addr),
    .wr_data   (fb_wr_data),
    .enable    (enable),
    .mode      (mode)
  );

  pixel_unpack u_unpack (
    .clk_pixel (clk_pixel),
    .arst_n    (arst_n),
    .rast      (rast.sink),
    .enable    (enable),
    .mode      (mode),
    .rd_addr   (fb_rd_addr),
    .rd_data   (fb_rd_data),
    .pix       (pix),
    .ctrl      (ctrl),
    .vde       (vde)
  );

  // syncs ride on blue only
  tmds_encoder u_tmds_blue (
    .clk_pixel (clk_pixel),
    .arst_n    (arst_n),
    .data      (pix.b),
    .ctrl      (ctrl),
    .vde       (vde),
    .tmds      (tmds_blue)
  );

  tmds_encoder u_tmds_green (
    .clk_pixel (clk_pixel),
    .arst_n    (arst_n),
    .data      (pix.g),
    .ctrl      (2'b00),
    .vde       (vde),
    .tmds      (tmds_green)
  );

  tmds_encoder u_tmds_red (
    .clk_pixel (clk_pixel),
    .arst_n    (arst_n),
    .data      (pix.r),
    .ctrl      (2'b00),
    .vde       (vde),
    .tmds      (tmds_red)
  );

endmodule

// File: logic/video_pkg.sv
package video_pkg;

  // one rgb565 pixel per word
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  // two gray pixels per word, left one in the low byte
  typedef struct packed {
    logic [7:0] gray_right;
    logic [7:0] gray_left;
  } mono2_t;

  // frame buffer word, read either way depending on mode
  typedef union packed {
    rgb565_t rgb;
    mono2_t  mono;
  } px_word_u;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  typedef logic [5:0] hpos_t; // 0..H_TOTAL-1
  typedef logic [4:0] vpos_t; // 0..V_TOTAL-1

endpackage

// File: logic/video_timing.sv
`timescale 1ns/1ps
`include "video_defs.svh"

module video_timing
  import video_pkg::*;
(
  input  logic     clk_pixel,
  input  logic     arst_n,
  raster_if.source rast
);
  localparam int HS_START = `H_ACTIVE + `H_FP;
  localparam int HS_END   = HS_START + `H_SYNC; // exclusive
  localparam int VS_START = `V_ACTIVE + `V_FP;
  localparam int VS_END   = VS_START + `V_SYNC;

  hpos_t h_nxt;
  vpos_t v_nxt;

  // next raster position, wraps at the totals
  always_comb begin
    h_nxt = rast.hpos + 1'b1;
    v_nxt = rast.vpos;
    if (rast.hpos == hpos_t'(`H_TOTAL - 1)) begin
      h_nxt = '0;
      v_nxt = (rast.vpos == vpos_t'(`V_TOTAL - 1)) ? '0 : rast.vpos + 1'b1;
    end
  end

  // flags are computed from the next position so they line up with it
  always_ff @(posedge clk_pixel or negedge arst_n) begin
    if (!arst_n) begin
      rast.hpos      <= '0;
      rast.vpos      <= '0;
      rast.active    <= 1'b1; // 0,0 is a visible pixel
      rast.hsync     <= 1'b0;
      rast.vsync     <= 1'b0;
      rast.new_frame <= 1'b0; // only completed frames pulse
    end else begin
      rast.hpos      <= h_nxt;
      rast.vpos      <= v_nxt;
      rast.active    <= (h_nxt < `H_ACTIVE) && (v_nxt < `V_ACTIVE);
      rast.hsync     <= (h_nxt >= HS_START) && (h_nxt < HS_END);
      rast.vsync     <= (v_nxt >= VS_START) && (v_nxt < VS_END);
      rast.new_frame <= (h_nxt == '0) && (v_nxt == '0);
    end
  end

endmodule

// File: verification/tb_video_out.sv
`timescale 1ns/1ps
`include "video_defs.svh"

module tb_video_out
  import video_pkg::*, regs_pkg::*;
();
  logic               clk_pixel;
  logic               arst_n;
  logic               psel;
  logic               penable;
  logic               pwrite;
  logic [`APB_AW-1:0] paddr;
  logic [31:0]        pwdata;
  logic [31:0]        prdata;
  logic               pready;
  logic               pslverr;
  logic [9:0]         tmds_blue;
  logic [9:0]         tmds_green;
  logic [9:0]         tmds_red;

  integer      seed = 32'h543b_182c;
  int          errors;
  int          checks;
  logic [15:0] shadow [`FB_DEPTH]; // model copy of the buffer
  logic        m_en;
  px_mode_e    m_mode;
  bit          running;            // raster model live
  bit          apb_busy;
  int          quiet;              // idle clocks since last apb transfer
  int          rh;
  int          rv;
  int          frames;
  int          sh_h [4];           // raster positions, newest first
  int          sh_v [4];
  bit          sh_ok [4];

  video_out_top dut (
    .clk_pixel (clk_pixel),
    .arst_n    (arst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .tmds_blue (tmds_blue),
    .tmds_green(tmds_green),
    .tmds_red  (tmds_red)
  );

  always #20 clk_pixel = ~clk_pixel; // 40 ns period

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_pixel(input string name, input rgb888_t got, input rgb888_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_ctrl(input string name, input logic [1:0] got, input logic [1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic abort_run(input string what);
    errors++;
    $display("timeout while waiting for %s", what);
    $display("%0d checks, %0d errors", checks, errors);
    $display("Some tests failed");
    $finish;
  endtask

  // dvi receiver side, undo inversion then the xor/xnor chain
  function automatic logic [7:0] tmds_data(input logic [9:0] w);
    logic [7:0] d;
    logic [7:0] q;
    d    = w[9] ? ~w[7:0] : w[7:0];
    q[0] = d[0];
    for (int i = 1; i < 8; i++) begin
      q[i] = w[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
    end
    return q;
  endfunction

  function automatic logic [1:0] tmds_ctrl(input logic [9:0] w);
    case (w)
      10'b1101010100: return 2'b00;
      10'b0010101011: return 2'b01;
      10'b0101010100: return 2'b10;
      10'b1010101011: return 2'b11;
      default:        return 2'bxx; // not a token at all
    endcase
  endfunction

  // expected screen pixel from the shadow buffer
  function automatic rgb888_t expect_pix(input int h, input int v);
    logic [15:0] w;
    logic [7:0]  gray;
    rgb888_t     p;
    w    = shadow[(v >> `SCALE_SHIFT) * `FB_W + (h >> `SCALE_SHIFT)];
    gray = h[`SCALE_SHIFT-1] ? w[15:8] : w[7:0]; // right byte on odd half cell
    if (!m_en) begin
      p = '0;
    end else if (m_mode == PX_MONO) begin
      p = '{r: gray, g: gray, b: gray};
    end else begin
      p = '{r: {w[15:11], 3'b000}, g: {w[10:5], 2'b00}, b: {w[4:0], 3'b000}};
    end
    return p;
  endfunction

  task automatic check_output(input int h, input int v);
    logic    act;
    logic    hs;
    logic    vs;
    rgb888_t got;
    act = (h < `H_ACTIVE) && (v < `V_ACTIVE);
    hs  = (h >= `H_ACTIVE + `H_FP) && (h < `H_ACTIVE + `H_FP + `H_SYNC);
    vs  = (v >= `V_ACTIVE + `V_FP) && (v < `V_ACTIVE + `V_FP + `V_SYNC);
    if (act) begin
      got = '{r: tmds_data(tmds_red), g: tmds_data(tmds_green), b: tmds_data(tmds_blue)};
      check_pixel("pixel", got, expect_pix(h, v));
    end else begin
      check_ctrl("tmds_blue ctrl", tmds_ctrl(tmds_blue), {vs, hs});
      check_ctrl("tmds_green ctrl", tmds_ctrl(tmds_green), 2'b00);
      check_ctrl("tmds_red ctrl", tmds_ctrl(tmds_red), 2'b00);
    end
  endtask

  // raster model, outputs are three clocks behind it
  always @(negedge clk_pixel) begin
    if (running) begin
      rh = rh + 1;
      if (rh == `H_TOTAL) begin
        rh = 0;
        rv = (rv == `V_TOTAL - 1) ? 0 : rv + 1;
        if (rv == 0) begin
          frames++; // back at 0,0
        end
      end
      for (int i = 3; i > 0; i--) begin
        sh_h[i]  = sh_h[i-1];
        sh_v[i]  = sh_v[i-1];
        sh_ok[i] = sh_ok[i-1];
      end
      sh_h[0]  = rh;
      sh_v[0]  = rv;
      sh_ok[0] = 1'b1;
      quiet = apb_busy ? 0 : ((quiet < 8) ? quiet + 1 : quiet);
      if (sh_ok[3] && quiet >= 5) begin // pipeline settled after register changes
        check_output(sh_h[3], sh_v[3]);
      end
    end
  end

  task automatic apb_xfer(input logic wr, input logic [`APB_AW-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int n;
    apb_busy = 1'b1;
    @(negedge clk_pixel);
    psel    = 1'b1; // setup
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk_pixel);
    penable = 1'b1; // access
    n = 0;
    @(posedge clk_pixel);
    while (!pready && n < 16) begin
      @(posedge clk_pixel);
      n++;
    end
    if (!pready) begin
      abort_run("pready");
    end else begin
      check_word("pready wait states", n, 32'h0); // due in the first access cycle
      rdata = prdata;
      err   = pslverr;
      @(negedge clk_pixel);
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      apb_busy = 1'b0;
    end
  endtask

  task automatic apb_write(input logic [`APB_AW-1:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [`APB_AW-1:0] addr, output logic [31:0] data,
                          output logic err);
    apb_xfer(1'b0, addr, 32'h0, data, err);
  endtask

  // wait for n more frame starts, then a couple of lines into the frame
  task automatic wait_frames(input int n);
    int target;
    int cnt;
    target = frames + n;
    cnt    = 0;
    while (!(frames >= target && rv >= 2) && cnt < (n + 1) * `H_TOTAL * `V_TOTAL) begin
      @(negedge clk_pixel);
      cnt++;
    end
    if (!(frames >= target && rv >= 2)) begin
      abort_run("frame count to advance");
    end
  endtask

  initial begin
    logic [31:0] w;
    logic [31:0] rd;
    logic [1:0]  c;
    logic        err;
    int          start;
    int          cnt;
    int          i;
    clk_pixel = 1'b0;
    arst_n    = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    m_en      = 1'b0;
    m_mode    = PX_RGB565;
    repeat (10) @(negedge clk_pixel);
    arst_n = 1'b1;
    @(posedge clk_pixel);
    running = 1'b1;

    // fill every word, upper pwdata bits are junk
    apb_write(REG_PIX_ADDR, 32'h0, err);
    for (i = 0; i < `FB_DEPTH; i++) begin
      w         = $random(seed);
      shadow[i] = w[15:0];
      apb_write(REG_PIX_DATA, w, err);
    end
    apb_read(REG_PIX_ADDR, rd, err);
    check_word("pix_addr", rd, 32'h0); // wrapped
    apb_read(REG_PIX_DATA, rd, err);
    check_word("pix_data", rd, 32'h0);

    // random start and length, often crosses the wrap
    start = {$random(seed)} % `FB_DEPTH;
    cnt   = 5 + {$random(seed)} % 60;
    apb_write(REG_PIX_ADDR, start, err);
    for (i = 0; i < cnt; i++) begin
      w = $random(seed);
      shadow[(start + i) % `FB_DEPTH] = w[15:0];
      apb_write(REG_PIX_DATA, w, err);
    end
    apb_read(REG_PIX_ADDR, rd, err);
    check_word("pix_addr", rd, (start + cnt) % `FB_DEPTH);

    // rgb, mono, mono disabled, disabled; at least one whole frame each
    for (i = 0; i < 4; i++) begin
      c = (i == 0) ? 2'b01 : (i == 1) ? 2'b11 : (i == 2) ? 2'b10 : 2'b00;
      w = $random(seed);
      apb_write(REG_CTRL, {w[31:2], c}, err);
      check_word("pslverr", err, 32'h0);
      apb_read(REG_CTRL, rd, err);
      check_word("ctrl", rd, {30'b0, c});
      m_en   = c[0];
      m_mode = px_mode_e'(c[1]);
      wait_frames(2);
    end

    // slave errors
    apb_read(4'h2, rd, err);
    check_word("pslverr", err, 32'h1);
    apb_write(4'h6, 32'h3, err);
    check_word("pslverr", err, 32'h1);
    apb_write(REG_STATUS, 32'h55, err);
    check_word("pslverr", err, 32'h1);

    wait_frames(2);
    apb_read(REG_STATUS, rd, err);
    check_word("frame_cnt", rd, frames % 256);

    errors += dut.u_tmds_blue.u_props.fails + dut.u_tmds_green.u_props.fails
            + dut.u_tmds_red.u_props.fails;
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: verification/video_out_props.sv
`timescale 1ns/1ps

// protocol checks on one tmds channel, bound into every encoder
module video_out_props (
  input logic              clk_pixel,
  input logic              arst_n,
  input logic              vde,
  input logic [9:0]        tmds,
  input logic signed [4:0] disparity
);
  int fails = 0; // read by the testbench at the end

  // dc balance stays inside the dvi bound
  a_disp_bound: assert property (@(posedge clk_pixel) disable iff (!arst_n)
    (disparity >= -8) && (disparity <= 8))
    else begin
      $error("running disparity out of range: %0d", disparity);
      fails++;
    end

  // a token follows blanking and never a data cycle
  a_ctrl_token: assert property (@(posedge clk_pixel) disable iff (!arst_n)
    (tmds inside {10'b1101010100, 10'b0010101011, 10'b0101010100, 10'b1010101011})
      == !$past(vde))
    else begin
      $error("tmds word %h does not match the blanking state", tmds);
      fails++;
    end

  a_no_x: assert property (@(posedge clk_pixel) disable iff (!arst_n) !$isunknown(tmds))
    else begin
      $error("tmds output has unknown bits");
      fails++;
    end

endmodule

bind tmds_encoder video_out_props u_props (
  .clk_pixel (clk_pixel),
  .arst_n    (arst_n),
  .vde       (vde),
  .tmds      (tmds),
  .disparity (disparity)
);

// File: video_out.f
+incdir+include
logic/video_pkg.sv
logic/regs_pkg.sv
logic/raster_if.sv
logic/video_timing.sv
logic/frame_buffer.sv
logic/fb_regs.sv
logic/pixel_unpack.sv
logic/tmds_encoder.sv
logic/video_out_top.sv
verification/video_out_props.sv
verification/tb_video_out.sv
